/* dv/vector_iir_checker.sv */
// Bound timing assertions for the vector IIR top level
// Sample and read latency, reset values, no X after reset

`timescale 1ns/1ps

module vector_iir_checker (
  input logic                                                        ce_clk,
  input logic                                                        rst_i,
  input logic [vector_iir_pkg::NUM_PORTS-1:0]                        in_valid_i,
  input logic [vector_iir_pkg::NUM_PORTS-1:0]                        out_valid_i,
  input logic [vector_iir_pkg::NUM_PORTS*vector_iir_pkg::SAMPLE_W-1:0] out_data_i,
  input logic                                                        reg_rd_i,
  input logic                                                        reg_rvalid_i,
  input logic [vector_iir_pkg::REG_W-1:0]                            reg_rdata_i
);
  import vector_iir_pkg::*;

  // Number of failed assertions so far
  int fail_cnt = 0;

  // One-cycle sample latency per port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    assert property (@(posedge ce_clk) disable iff (rst_i)
      out_valid_i[p] == $past(in_valid_i[p]))
      else begin
        $error("Port %0d out_valid does not follow in_valid by one cycle", p);
        fail_cnt++;
      end
  end

  // Read answer one cycle after the strobe
  assert property (@(posedge ce_clk) disable iff (rst_i)
    reg_rvalid_i == $past(reg_rd_i))
    else begin
      $error("reg_rvalid does not follow reg_rd by one cycle");
      fail_cnt++;
    end

  // Held low through reset
  assert property (@(posedge ce_clk) rst_i && $past(rst_i) |->
    (out_valid_i == '0) && !reg_rvalid_i)
    else begin
      $error("Outputs not low during reset");
      fail_cnt++;
    end

  assert property (@(posedge ce_clk) disable iff (rst_i)
    !$isunknown({out_valid_i, out_data_i, reg_rvalid_i, reg_rdata_i}))
    else begin
      $error("Unknown value on a top-level output");
      fail_cnt++;
    end

endmodule

/* dv/vector_iir_tb.sv */
// Testbench for the vector IIR filter
// Clock, reset, register and sample stimulus, reference model
// Compare process and final report

`timescale 1ns/1ps

module vector_iir_tb;
  import vector_iir_pkg::*;

  // About 2.5 times the stimulus length of roughly 1600 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic                          ce_clk = 1'b0;
  logic                          rst_i;
  logic [NUM_PORTS-1:0]          in_valid_i;
  logic [NUM_PORTS*SAMPLE_W-1:0] in_data_i;
  logic [NUM_PORTS-1:0]          out_valid_o;
  logic [NUM_PORTS*SAMPLE_W-1:0] out_data_o;
  logic                          reg_wr_i;
  logic                          reg_rd_i;
  logic [ADDR_W-1:0]             reg_addr_i;
  logic [REG_W-1:0]              reg_wdata_i;
  logic [REG_W-1:0]              reg_rdata_o;
  logic                          reg_rvalid_o;

  integer seed = 32'hdbf0;
  int     cycle_cnt = 0;
  string  test_name = "reset";

  // Model state with past outputs, pointers and register mirror
  sample_u                  hist [NUM_PORTS][MAX_DELAY];
  int                       ptr [NUM_PORTS];
  logic [DELAY_W-1:0]       m_delay [NUM_PORTS];
  logic signed [COMP_W-1:0] m_alpha [NUM_PORTS];
  logic signed [COMP_W-1:0] m_beta [NUM_PORTS];
  // Expected results in arrival order
  sample_u                  exp_q [NUM_PORTS][$];
  logic [REG_W-1:0]         exp_reg_q [$];

  vector_iir_top UUT (.*);

  bind vector_iir_top vector_iir_checker u_checker (
    .ce_clk       (ce_clk),
    .rst_i        (rst_i),
    .in_valid_i   (in_valid_i),
    .out_valid_i  (out_valid_o),
    .out_data_i   (out_data_o),
    .reg_rd_i     (reg_rd_i),
    .reg_rvalid_i (reg_rvalid_o),
    .reg_rdata_i  (reg_rdata_o)
  );

  always #20 ce_clk = ~ce_clk;

  // --------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------
  // beta*x + alpha*yd floored to Q1.15 and clipped to +-FXP_MAX
  function automatic logic signed [COMP_W-1:0] lane_ref(
    input logic signed [COMP_W-1:0] x, yd, a, b);
    longint acc;
    acc = (longint'(x) * longint'(b) + longint'(yd) * longint'(a)) >>> FRAC_W;
    if (acc > FXP_MAX) return COMP_W'(FXP_MAX);
    if (acc < -FXP_MAX) return COMP_W'(-FXP_MAX);
    return COMP_W'(acc);
  endfunction

  function automatic sample_u model_step(input int p, input sample_u x);
    sample_u y;
    int      last;
    y.iq[I_IDX] = lane_ref(x.iq[I_IDX], hist[p][ptr[p]].iq[I_IDX], m_alpha[p], m_beta[p]);
    y.iq[Q_IDX] = lane_ref(x.iq[Q_IDX], hist[p][ptr[p]].iq[Q_IDX], m_alpha[p], m_beta[p]);
    hist[p][ptr[p]] = y;
    // Delay 0 behaves as 1
    last   = (m_delay[p] == 0) ? 0 : m_delay[p] - 1;
    ptr[p] = (ptr[p] >= last) ? 0 : ptr[p] + 1;
    return y;
  endfunction

  // Expected readback from the register map
  function automatic logic [REG_W-1:0] reg_word(input int p, input logic [OFFS_W-1:0] offs);
    logic [REG_W-1:0] w;
    w = '0;
    // Ports past the last one are unmapped
    if (p < NUM_PORTS) begin
      case (offs)
        REG_DELAY: begin
          w[REG_DELAY_POS +: DELAY_W]     = m_delay[p];
          w[REG_MAX_DELAY_POS +: DELAY_W] = DELAY_W'(MAX_DELAY);
        end
        REG_ALPHA: w[REG_COEF_LEN-1:0] = m_alpha[p];
        REG_BETA:  w[REG_COEF_LEN-1:0] = m_beta[p];
        default:   w = '0;
      endcase
    end
    return w;
  endfunction

  function automatic sample_u iq(input int i, input int q);
    sample_u s;
    s.iq[I_IDX] = COMP_W'(i);
    s.iq[Q_IDX] = COMP_W'(q);
    return s;
  endfunction

  function automatic logic signed [COMP_W-1:0] to_q15(input real r);
    if (r >= 1.0) return COMP_W'(FXP_MAX);
    return COMP_W'($rtoi(r * 32768.0 + 0.5));
  endfunction

  // Quarter-rate sine of amplitude 20000
  function automatic int qsin(input int n);
    case (n % 4)
      1:       return 20000;
      3:       return -20000;
      default: return 0;
    endcase
  endfunction

  function automatic int pending();
    int n;
    n = exp_reg_q.size();
    for (int p = 0; p < NUM_PORTS; p++) n += exp_q[p].size();
    return n;
  endfunction

  // --------------------------------------------------------------------
  // Reporting and compare
  // --------------------------------------------------------------------
  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_sample(input string what, input sample_u exp_v, input sample_u act_v);
    if (act_v !== exp_v)
      report_fail($sformatf("Fail %s, %s: expected %h actual %h",
                            test_name, what, exp_v.raw, act_v.raw));
  endtask

  task automatic check_reg(input logic [REG_W-1:0] exp_v, input logic [REG_W-1:0] act_v);
    if (act_v !== exp_v)
      report_fail($sformatf("Fail %s, register read: expected %h actual %h",
                            test_name, exp_v, act_v));
  endtask

  // Outputs are settled mid-cycle
  always @(negedge ce_clk) begin : compare
    sample_u got;
    if (!rst_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (out_valid_o[p]) begin
          got = out_data_o[p*SAMPLE_W +: SAMPLE_W];
          if (exp_q[p].size() == 0)
            report_fail($sformatf("Port %0d gave an output with no sample sent", p));
          else
            check_sample($sformatf("port %0d", p), exp_q[p].pop_front(), got);
        end
      end
      if (reg_rvalid_o) begin
        if (exp_reg_q.size() == 0)
          report_fail("Register read data came back with no read issued");
        else
          check_reg(exp_reg_q.pop_front(), reg_rdata_o);
      end
    end
  end

  always @(posedge ce_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      report_fail("Timeout, the run did not finish within the cycle limit");
  end

  // --------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------
  // Strobes drop unless the caller raises them again
  task automatic next_cycle();
    @(posedge ce_clk);
    #2;
    in_valid_i = '0;
    reg_wr_i   = 1'b0;
    reg_rd_i   = 1'b0;
  endtask

  task automatic reg_write(input int p, input logic [OFFS_W-1:0] offs,
                           input logic [REG_W-1:0] d);
    next_cycle();
    reg_wr_i    = 1'b1;
    reg_addr_i  = {(ADDR_W-OFFS_W)'(p), offs};
    reg_wdata_i = d;
    case (offs)
      REG_DELAY: begin
        // History cleared and pointer back to 0
        m_delay[p] = d[REG_DELAY_POS +: DELAY_W];
        ptr[p]     = 0;
        for (int i = 0; i < MAX_DELAY; i++) hist[p][i] = '0;
      end
      REG_ALPHA: m_alpha[p] = d[REG_COEF_LEN-1:0];
      REG_BETA:  m_beta[p]  = d[REG_COEF_LEN-1:0];
      default: ;
    endcase
  endtask

  task automatic reg_read(input int p, input logic [OFFS_W-1:0] offs);
    next_cycle();
    reg_rd_i   = 1'b1;
    reg_addr_i = {(ADDR_W-OFFS_W)'(p), offs};
    exp_reg_q.push_back(reg_word(p, offs));
  endtask

  task automatic setup(input int p, input int dly, input logic signed [COMP_W-1:0] a, b);
    reg_write(p, REG_DELAY, REG_W'(dly));
    reg_write(p, REG_ALPHA, {{(REG_W-COMP_W){1'b0}}, a});
    reg_write(p, REG_BETA, {{(REG_W-COMP_W){1'b0}}, b});
  endtask

  task automatic send(input logic [NUM_PORTS-1:0] vld, input sample_u d0, input sample_u d1);
    sample_u d [NUM_PORTS];
    d[0] = d0;
    d[1] = d1;
    next_cycle();
    in_valid_i = vld;
    for (int p = 0; p < NUM_PORTS; p++) begin
      in_data_i[p*SAMPLE_W +: SAMPLE_W] = d[p];
      if (vld[p]) exp_q[p].push_back(model_step(p, d[p]));
    end
  endtask

  // Wait a few cycles for queued results of one-cycle latency
  task automatic drain();
    int n;
    n = 0;
    next_cycle();
    while (n < 4 && pending() != 0) begin
      @(negedge ce_clk);
      n++;
    end
    if (pending() != 0) report_fail("Missing output, queued results never arrived");
  endtask

  initial begin
    int      x;
    int      a;
    sample_u s;
    sample_u rnd;
    rst_i       = 1'b1;
    in_valid_i  = '0;
    in_data_i   = '0;
    reg_wr_i    = 1'b0;
    reg_rd_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    // Reset state with delay 1, zero coefficients and empty history
    for (int p = 0; p < NUM_PORTS; p++) begin
      m_delay[p] = DELAY_W'(1);
      m_alpha[p] = '0;
      m_beta[p]  = '0;
      ptr[p]     = 0;
      for (int i = 0; i < MAX_DELAY; i++) hist[p][i] = '0;
    end
    repeat (3) @(posedge ce_clk);
    #2;
    rst_i = 1'b0;

    test_name = "register access";
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int r = 0; r < 3; r++) reg_read(p, OFFS_W'(4 * r));
      for (int v = 0; v < 2; v++) begin
        for (int r = 0; r < 3; r++) begin
          reg_write(p, OFFS_W'(4 * r), v ? '1 : '0);
          reg_read(p, OFFS_W'(4 * r));
        end
      end
      // Unmapped offset
      reg_read(p, 4'hc);
    end
    // Port number beyond the last channel
    reg_read(NUM_PORTS, REG_DELAY);
    drain();

    test_name = "impulse and step";
    for (int p = 0; p < NUM_PORTS; p++) begin
      setup(p, 8, to_q15(0.7), to_q15(0.3));
      for (int n = 0; n < 40 * 8; n++) begin
        x = (n < 8 || n >= 20 * 8) ? FXP_MAX : 0;
        send(NUM_PORTS'(1 << p), iq(x, -x), iq(x, -x));
      end
    end
    drain();

    test_name = "element independence";
    for (int p = 0; p < NUM_PORTS; p++) begin
      setup(p, 9, to_q15(0.9), to_q15(0.1));
      for (int n = 0; n < 24; n++) begin
        for (int e = 0; e < 9; e++) begin
          case (e % 3)
            0:       s = iq(qsin(n), qsin(n + 1));
            1:       s = iq(qsin(n + 1), qsin(n));
            default: s = iq(0, 0);
          endcase
          send(NUM_PORTS'(1 << p), s, s);
        end
      end
    end
    drain();

    test_name = "port independence";
    setup(0, 5, to_q15(0.7), to_q15(0.3));
    setup(1, $random(seed) & MAX_DELAY, COMP_W'($random(seed)), COMP_W'($random(seed)));
    for (int n = 0; n < 300; n++) begin
      x       = (n < 20) ? 0 : 20000;
      a       = $random(seed);
      rnd.raw = $random(seed);
      // Port 1 valid at random and port 0 every cycle
      send({a[0], 1'b1}, iq(x, -x), rnd);
    end
    drain();

    test_name = "delay rewrite";
    setup(0, 8, to_q15(0.7), to_q15(0.3));
    for (int n = 0; n < 30; n++) send(2'b01, iq(12000, -9000), iq(0, 0));
    // Next 5 outputs are beta*x only
    reg_write(0, REG_DELAY, REG_W'(5));
    for (int n = 0; n < 15; n++) send(2'b01, iq(12000, -9000), iq(0, 0));
    drain();

    test_name = "saturation";
    setup(1, 4, COMP_W'(FXP_MAX), COMP_W'(FXP_MAX));
    for (int n = 0; n < 24; n++) send(2'b10, iq(0, 0), iq(FXP_MAX, -32768));
    drain();

    if (pending() == 0 && UUT.u_checker.fail_cnt == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      report_fail("Timing assertions in the checker failed");
    end
  end

endmodule

/* filelist.f */
verilog/vector_iir_pkg.sv
verilog/vector_iir_cfg_if.sv
verilog/vector_iir_regs.sv
verilog/vector_delay_line.sv
verilog/iir_lane.sv
verilog/vector_iir_channel.sv
verilog/vector_iir_top.sv
dv/vector_iir_checker.sv
dv/vector_iir_tb.sv

/* verilog/iir_lane.sv */
// One real-valued filter lane
// y = beta*x + alpha*yd, floor to Q1.15, symmetric saturation

`timescale 1ns/1ps

module iir_lane (
  input  logic signed [vector_iir_pkg::COMP_W-1:0] x_i,
  input  logic signed [vector_iir_pkg::COMP_W-1:0] yd_i,
  input  logic signed [vector_iir_pkg::COMP_W-1:0] alpha_i,
  input  logic signed [vector_iir_pkg::COMP_W-1:0] beta_i,
  output logic signed [vector_iir_pkg::COMP_W-1:0] y_o
);
  import vector_iir_pkg::*;

  // Q2.30 products
  logic signed [PROD_W-1:0] prod_x;
  logic signed [PROD_W-1:0] prod_y;
  // One guard bit for the sum
  logic signed [ACC_W-1:0]  acc;
  logic signed [ACC_W-1:0]  acc_sh;

  // ----------------------------------------------------------------------
  // Multiply-add at full precision
  // ----------------------------------------------------------------------
  assign prod_x = x_i * beta_i;
  assign prod_y = yd_i * alpha_i;
  assign acc    = prod_x + prod_y;

  // Back to Q1.15, rounds toward minus infinity
  assign acc_sh = acc >>> FRAC_W;

  // ----------------------------------------------------------------------
  // Saturation
  // ----------------------------------------------------------------------
  always_comb begin
    if (acc_sh > FXP_MAX) begin
      y_o = COMP_W'(FXP_MAX);
    end else if (acc_sh < -FXP_MAX) begin
      // Clip to -32767, keeps the range symmetric
      y_o = COMP_W'(-FXP_MAX);
    end else begin
      y_o = acc_sh[COMP_W-1:0];
    end
  end

endmodule

/* verilog/vector_delay_line.sv */
// Circular history of past filter outputs
// Length follows the programmed delay, cleared by a delay write

`timescale 1ns/1ps

module vector_delay_line (
  input  logic                               ce_clk,
  input  logic                               rst_i,
  input  logic                               clear_i,
  input  logic [vector_iir_pkg::DELAY_W-1:0] delay_i,
  input  logic                               wr_i,
  input  vector_iir_pkg::sample_u            wr_data_i,
  output vector_iir_pkg::sample_u            rd_data_o
);
  import vector_iir_pkg::*;

  sample_u              mem [MAX_DELAY];
  // Entry written since the last clear
  logic [MAX_DELAY-1:0] vld;
  logic [DELAY_W-1:0]   ptr;
  logic [DELAY_W-1:0]   ptr_eff;
  logic [DELAY_W-1:0]   last_idx;
  logic [DELAY_W-1:0]   ptr_nxt;

  // A clear pulse acts on the sample accepted in the same cycle
  assign ptr_eff  = clear_i ? '0 : ptr;
  // Delay of 0 treated as 1
  assign last_idx = (delay_i == '0) ? '0 : delay_i - DELAY_W'(1);
  // Wrap also catches a pointer left beyond a shorter vector
  assign ptr_nxt  = (ptr_eff >= last_idx) ? '0 : ptr_eff + DELAY_W'(1);

  // Stale or cleared entries read as zero
  assign rd_data_o = (clear_i || !vld[ptr_eff]) ? '0 : mem[ptr_eff];

  // Control state
  always_ff @(posedge ce_clk) begin
    if (rst_i) begin
      ptr <= '0;
      vld <= '0;
    end else begin
      if (clear_i) begin
        vld <= '0;
        ptr <= '0;
      end
      if (wr_i) begin
        vld[ptr_eff] <= 1'b1;
        ptr          <= ptr_nxt;
      end
    end
  end

  // Storage, no reset needed
  always_ff @(posedge ce_clk) begin
    if (wr_i) begin
      mem[ptr_eff] <= wr_data_i;
    end
  end

endmodule

/* verilog/vector_iir_cfg_if.sv */
// Per-port configuration bundle
// Register block drives it, one filter channel consumes it

`timescale 1ns/1ps

interface vector_iir_cfg_if;
  import vector_iir_pkg::*;

  // Vector length, 0 behaves as 1
  logic [DELAY_W-1:0]       delay;
  // Feedback coefficient, Q1.15
  logic signed [COMP_W-1:0] alpha;
  // Input coefficient, Q1.15
  logic signed [COMP_W-1:0] beta;
  // One-cycle pulse after a delay write
  logic                     clear;

  modport regs (
    output delay,
    output alpha,
    output beta,
    output clear
  );

  modport channel (
    input delay,
    input alpha,
    input beta,
    input clear
  );

endinterface

/* verilog/vector_iir_channel.sv */
// One port of the vector IIR filter
// History buffer, I and Q lanes, registered output

`timescale 1ns/1ps

module vector_iir_channel (
  input  logic                    ce_clk,
  input  logic                    rst_i,
  vector_iir_cfg_if.channel       cfg,
  input  logic                    in_valid_i,
  input  vector_iir_pkg::sample_u in_data_i,
  output logic                    out_valid_o,
  output vector_iir_pkg::sample_u out_data_o
);
  import vector_iir_pkg::*;

  // Output from one vector earlier, same element
  sample_u           hist;
  sample_u           y_c;
  logic [COMP_W-1:0] y_i;
  logic [COMP_W-1:0] y_q;

  // History, written with the same value as the output register
  vector_delay_line u_delay (
    .ce_clk    (ce_clk),
    .rst_i     (rst_i),
    .clear_i   (cfg.clear),
    .delay_i   (cfg.delay),
    .wr_i      (in_valid_i),
    .wr_data_i (y_c),
    .rd_data_o (hist)
  );

  // In-phase
  iir_lane u_lane_i (
    .x_i     (in_data_i.iq[I_IDX]),
    .yd_i    (hist.iq[I_IDX]),
    .alpha_i (cfg.alpha),
    .beta_i  (cfg.beta),
    .y_o     (y_i)
  );

  // Quadrature
  iir_lane u_lane_q (
    .x_i     (in_data_i.iq[Q_IDX]),
    .yd_i    (hist.iq[Q_IDX]),
    .alpha_i (cfg.alpha),
    .beta_i  (cfg.beta),
    .y_o     (y_q)
  );

  always_comb begin
    y_c.iq[I_IDX] = y_i;
    y_c.iq[Q_IDX] = y_q;
  end

  // One cycle latency, new sample every cycle
  always_ff @(posedge ce_clk) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
      out_data_o  <= '0;
    end else begin
      out_valid_o <= in_valid_i;
      if (in_valid_i) begin
        out_data_o <= y_c;
      end
    end
  end

endmodule

/* verilog/vector_iir_pkg.sv */
// Shared constants for the vector IIR filter
// Register map, field positions, fixed-point widths
// Sample word type seen as raw bits or as an I/Q pair

package vector_iir_pkg;

  // ----------------------------------------------------------------------
  // Sizing
  // ----------------------------------------------------------------------
  localparam int NUM_PORTS = 2;
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
  localparam int SAMPLE_W  = 32;
  localparam int COMP_W    = 16;
  // Q1.15 fraction bits
  localparam int FRAC_W    = 15;
  // Symmetric clip range, -32768 never produced
  localparam int FXP_MAX   = 32767;
  // Full-precision product and sum widths
  localparam int PROD_W    = 2 * COMP_W;
  localparam int ACC_W     = 2 * COMP_W + 1;
  localparam int MAX_DELAY = 63;
  localparam int DELAY_W   = 6;
  // Which half of the word holds I and which holds Q
  localparam int I_IDX     = 1;
  localparam int Q_IDX     = 0;

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------
  localparam int REG_W  = 32;
  localparam int ADDR_W = 8;
  // Low address bits give the byte offset, high bits the port
  localparam int OFFS_W = 4;
  localparam logic [OFFS_W-1:0] REG_DELAY = 4'h0;
  localparam logic [OFFS_W-1:0] REG_ALPHA = 4'h4;
  localparam logic [OFFS_W-1:0] REG_BETA  = 4'h8;
  localparam int REG_DELAY_POS     = 0;
  localparam int REG_MAX_DELAY_POS = 16;
  // Alpha and beta both sit at bit 0
  localparam int REG_COEF_LEN      = 16;

  // One item, bus view and datapath view
  typedef union packed {
    logic [SAMPLE_W-1:0]                raw;
    logic signed [1:0][COMP_W-1:0]      iq;
  } sample_u;

endpackage

/* verilog/vector_iir_regs.sv */
// Register block for all filter ports
// Write decode, per-port delay/alpha/beta storage, readback mux

`timescale 1ns/1ps

module vector_iir_regs (
  input  logic                              ce_clk,
  input  logic                              rst_i,
  input  logic                              reg_wr_i,
  input  logic                              reg_rd_i,
  input  logic [vector_iir_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [vector_iir_pkg::REG_W-1:0]  reg_wdata_i,
  output logic [vector_iir_pkg::REG_W-1:0]  reg_rdata_o,
  output logic                              reg_rvalid_o,
  vector_iir_cfg_if.regs                    cfg [vector_iir_pkg::NUM_PORTS]
);
  import vector_iir_pkg::*;

  logic [ADDR_W-OFFS_W-1:0] port_sel;
  logic [OFFS_W-1:0]        offs;
  logic [PORT_W-1:0]        port_idx;
  logic                     port_ok;
  // Per-port copies gathered for the read mux
  logic [DELAY_W-1:0]       delay_arr [NUM_PORTS];
  logic [COMP_W-1:0]        alpha_arr [NUM_PORTS];
  logic [COMP_W-1:0]        beta_arr  [NUM_PORTS];
  logic [REG_W-1:0]         rdata_c;

  // Address split
  assign port_sel = reg_addr_i[ADDR_W-1:OFFS_W];
  assign offs     = reg_addr_i[OFFS_W-1:0];
  assign port_idx = port_sel[PORT_W-1:0];
  assign port_ok  = (port_sel < NUM_PORTS);

  // ----------------------------------------------------------------------
  // Per-port storage
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    logic [DELAY_W-1:0] delay_q;
    logic [COMP_W-1:0]  alpha_q;
    logic [COMP_W-1:0]  beta_q;
    logic               clear_q;
    logic               wr_hit;

    assign wr_hit = reg_wr_i && (port_sel == (ADDR_W-OFFS_W)'(p));

    always_ff @(posedge ce_clk) begin
      if (rst_i) begin
        delay_q <= DELAY_W'(1);
        alpha_q <= '0;
        beta_q  <= '0;
        clear_q <= 1'b0;
      end else begin
        // Clear only lasts the cycle after the write
        clear_q <= 1'b0;
        if (wr_hit) begin
          case (offs)
            REG_DELAY: begin
              delay_q <= reg_wdata_i[REG_DELAY_POS +: DELAY_W];
              clear_q <= 1'b1;
            end
            REG_ALPHA: alpha_q <= reg_wdata_i[0 +: REG_COEF_LEN];
            REG_BETA:  beta_q  <= reg_wdata_i[0 +: REG_COEF_LEN];
            default: ;
          endcase
        end
      end
    end

    // Out to the channel
    assign cfg[p].delay = delay_q;
    assign cfg[p].alpha = alpha_q;
    assign cfg[p].beta  = beta_q;
    assign cfg[p].clear = clear_q;

    assign delay_arr[p] = delay_q;
    assign alpha_arr[p] = alpha_q;
    assign beta_arr[p]  = beta_q;
  end

  // ----------------------------------------------------------------------
  // Readback
  // ----------------------------------------------------------------------
  always_comb begin
    rdata_c = '0;
    if (port_ok) begin
      case (offs)
        REG_DELAY: begin
          rdata_c[REG_DELAY_POS +: DELAY_W]     = delay_arr[port_idx];
          // Read-only field, fixed at build time
          rdata_c[REG_MAX_DELAY_POS +: DELAY_W] = DELAY_W'(MAX_DELAY);
        end
        REG_ALPHA: rdata_c[0 +: REG_COEF_LEN] = alpha_arr[port_idx];
        REG_BETA:  rdata_c[0 +: REG_COEF_LEN] = beta_arr[port_idx];
        default:   rdata_c = '0;
      endcase
    end
  end

  // Read answer one cycle after the strobe
  always_ff @(posedge ce_clk) begin
    if (rst_i) begin
      reg_rvalid_o <= 1'b0;
      reg_rdata_o  <= '0;
    end else begin
      reg_rvalid_o <= reg_rd_i;
      if (reg_rd_i) begin
        reg_rdata_o <= rdata_c;
      end
    end
  end

endmodule

/* verilog/vector_iir_top.sv */
// Top level of the multi-port vector IIR filter
// Register block plus one channel per port

`timescale 1ns/1ps

module vector_iir_top (
  input  logic                                                        ce_clk,
  input  logic                                                        rst_i,
  // Sample inputs, one slice per port
  input  logic [vector_iir_pkg::NUM_PORTS-1:0]                        in_valid_i,
  input  logic [vector_iir_pkg::NUM_PORTS*vector_iir_pkg::SAMPLE_W-1:0] in_data_i,
  // Sample outputs
  output logic [vector_iir_pkg::NUM_PORTS-1:0]                        out_valid_o,
  output logic [vector_iir_pkg::NUM_PORTS*vector_iir_pkg::SAMPLE_W-1:0] out_data_o,
  // Register access
  input  logic                                                        reg_wr_i,
  input  logic                                                        reg_rd_i,
  input  logic [vector_iir_pkg::ADDR_W-1:0]                           reg_addr_i,
  input  logic [vector_iir_pkg::REG_W-1:0]                            reg_wdata_i,
  output logic [vector_iir_pkg::REG_W-1:0]                            reg_rdata_o,
  output logic                                                        reg_rvalid_o
);
  import vector_iir_pkg::*;

  // Config bundle per port
  vector_iir_cfg_if cfg [NUM_PORTS] ();

  vector_iir_regs u_regs (
    .ce_clk       (ce_clk),
    .rst_i        (rst_i),
    .reg_wr_i     (reg_wr_i),
    .reg_rd_i     (reg_rd_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .reg_rvalid_o (reg_rvalid_o),
    .cfg          (cfg)
  );

  // ----------------------------------------------------------------------
  // Identical channels, each owns its output slice
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_chan
    vector_iir_channel u_chan (
      .ce_clk      (ce_clk),
      .rst_i       (rst_i),
      .cfg         (cfg[p]),
      .in_valid_i  (in_valid_i[p]),
      .in_data_i   (in_data_i[p*SAMPLE_W +: SAMPLE_W]),
      .out_valid_o (out_valid_o[p]),
      .out_data_o  (out_data_o[p*SAMPLE_W +: SAMPLE_W])
    );
  end

endmodule
